// File: verilog/alu_defs.svh
// ====================
// width macros for the execute ALU
// ====================

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// full data path width
`define ALU_XLEN 64

// low part kept in word mode
`define ALU_WORD_W 32

// shift amount field taken from operand b
`define ALU_SHAMT_W 6

`endif

// File: verilog/alu_pkg.sv
// ====================
// ALU operation encoding and data word type
// ====================

`include "alu_defs.svh"

package alu_pkg;

    typedef logic [`ALU_XLEN-1:0] xlen_t;

    // ====================
    // operation select
    // ====================
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_slt    = 4'd2,
        op_sltu   = 4'd3,
        op_and    = 4'd4,
        op_or     = 4'd5,
        op_xor    = 4'd6,
        op_sll    = 4'd7,
        op_srl    = 4'd8,
        op_sra    = 4'd9,
        // result is operand b as is
        op_pass   = 4'd10,
        // multiplies, handled by the sequencer
        op_mul    = 4'd11,
        op_mulh   = 4'd12,
        op_mulhu  = 4'd13,
        op_mulhsu = 4'd14
    } alu_op_e;

endpackage

// File: verilog/mul_pkg.sv
// ====================
// multiply signedness and sequencer states
// ====================

package mul_pkg;

    // upper bit: multiplicand signed, lower bit: multiplier signed
    typedef enum logic [1:0] {
        mul_uu = 2'b00,
        mul_su = 2'b10,
        mul_ss = 2'b11
    } mul_sign_e;

    // ====================
    // ALU sequencer
    // ====================
    typedef enum logic [1:0] {
        seq_idle    = 2'd0,
        seq_request = 2'd1,
        seq_wait    = 2'd2
    } seq_state_e;

endpackage

// File: verilog/mul_if.sv
// ====================
// multiply request and response
// ====================

`timescale 1ns/1ps

interface mul_if;

    // request side
    logic                valid;
    logic                word;
    mul_pkg::mul_sign_e  sign;
    alu_pkg::xlen_t      multiplicand;
    alu_pkg::xlen_t      multiplier;

    // response side
    logic                ready;
    logic                done;
    alu_pkg::xlen_t      hi;
    alu_pkg::xlen_t      lo;

    modport requester (
        output valid, word, sign, multiplicand, multiplier,
        input  ready, done, hi, lo
    );

    modport responder (
        input  valid, word, sign, multiplicand, multiplier,
        output ready, done, hi, lo
    );

endinterface

// File: verilog/alu_shifter.sv
// ====================
// log barrel shifter for sll, srl and sra
// ====================

`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_shifter (
    input  logic [`ALU_XLEN-1:0]    din,
    input  logic [`ALU_SHAMT_W-1:0] shamt,
    input  logic                    left,
    input  logic                    arith,
    output logic [`ALU_XLEN-1:0]    dout
);

    logic                stage [0:`ALU_SHAMT_W-1];
    logic [`ALU_XLEN-1:0] data [0:`ALU_SHAMT_W];
    logic                fill;

    // sign fill only for arithmetic right shifts
    assign fill = arith & din[`ALU_XLEN-1];

    assign data[0] = din;

    for (genvar k = 0; k < `ALU_SHAMT_W; k++) begin : g_stage
        localparam int S = 1 << k;

        assign stage[k] = shamt[k];
        assign data[k+1] = !stage[k] ? data[k] :
                           left      ? {data[k][`ALU_XLEN-1-S:0], {S{1'b0}}} :
                                       {{S{fill}}, data[k][`ALU_XLEN-1:S]};
    end

    assign dout = data[`ALU_SHAMT_W];

endmodule

// File: verilog/alu_datapath.sv
// ====================
// single-cycle ALU datapath
// word cut, adder, compare flags and result select
// ====================

`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_datapath (
    input  alu_pkg::alu_op_e op,
    input  logic             word,
    input  alu_pkg::xlen_t   da,
    input  alu_pkg::xlen_t   db,
    output alu_pkg::xlen_t   a_cut,
    output alu_pkg::xlen_t   b_cut,
    output alu_pkg::xlen_t   comb_result,
    output logic             comb_less,
    output logic             comb_zero
);

    localparam int MSB = `ALU_XLEN - 1;

    logic           sub;
    logic           uns;
    alu_pkg::xlen_t b_inv;
    alu_pkg::xlen_t sum;
    logic           carry;
    logic           overflow;
    alu_pkg::xlen_t shift_out;

    // word mode keeps only the low half, upper bits zero
    assign a_cut = word ? {{(`ALU_XLEN-`ALU_WORD_W){1'b0}}, da[`ALU_WORD_W-1:0]} : da;
    assign b_cut = word ? {{(`ALU_XLEN-`ALU_WORD_W){1'b0}}, db[`ALU_WORD_W-1:0]} : db;

    // ====================
    // adder / subtractor
    // ====================
    assign sub = (op == alu_pkg::op_sub) || (op == alu_pkg::op_slt) ||
                 (op == alu_pkg::op_sltu);
    assign uns = (op == alu_pkg::op_sltu);

    assign b_inv = b_cut ^ {`ALU_XLEN{sub}};
    assign {carry, sum} = a_cut + b_inv + {{(`ALU_XLEN-1){1'b0}}, sub};

    assign overflow = (a_cut[MSB] == b_inv[MSB]) && (a_cut[MSB] != sum[MSB]);

    // no carry out of a - b means a borrow
    assign comb_less = uns ? (carry ^ sub) : (overflow ^ sum[MSB]);
    assign comb_zero = (sum == '0);

    alu_shifter i_shifter (
        .din   (a_cut),
        .shamt (b_cut[`ALU_SHAMT_W-1:0]),
        .left  (op == alu_pkg::op_sll),
        .arith (op == alu_pkg::op_sra),
        .dout  (shift_out)
    );

    // ====================
    // result select
    // ====================
    always_comb begin
        unique case (op)
            alu_pkg::op_add,
            alu_pkg::op_sub:  comb_result = sum;
            alu_pkg::op_slt,
            alu_pkg::op_sltu: comb_result = {{(`ALU_XLEN-1){1'b0}}, comb_less};
            alu_pkg::op_and:  comb_result = a_cut & b_cut;
            alu_pkg::op_or:   comb_result = a_cut | b_cut;
            alu_pkg::op_xor:  comb_result = a_cut ^ b_cut;
            alu_pkg::op_sll,
            alu_pkg::op_srl,
            alu_pkg::op_sra:  comb_result = shift_out;
            alu_pkg::op_pass: comb_result = b_cut;
            // multiplies come back through the sequencer
            default:          comb_result = '0;
        endcase
    end

endmodule

// File: verilog/alu_sequencer.sv
// ====================
// ALU sequencer, multiply launch and registered outputs
// ====================

`timescale 1ns/1ps

module alu_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             stall,
    input  alu_pkg::alu_op_e op,
    input  logic             word,
    input  alu_pkg::xlen_t   a_cut,
    input  alu_pkg::xlen_t   b_cut,
    input  alu_pkg::xlen_t   comb_result,
    input  logic             comb_less,
    input  logic             comb_zero,
    mul_if.requester         mul,
    output logic             alu_valid,
    output alu_pkg::xlen_t   result,
    output logic             less,
    output logic             zero
);

    mul_pkg::seq_state_e state;
    mul_pkg::seq_state_e next_state;

    logic               is_mul_op;
    logic               want_hi;
    mul_pkg::mul_sign_e op_sign;
    logic               sel_hi;
    logic               clear;
    logic               launch;
    logic               accept;
    logic               finish;
    logic               capture;

    // decode of the multiply flavour
    always_comb begin
        is_mul_op = 1'b1;
        want_hi   = 1'b1;
        op_sign   = mul_pkg::mul_ss;
        unique case (op)
            alu_pkg::op_mul:    want_hi = 1'b0;
            alu_pkg::op_mulh:   op_sign = mul_pkg::mul_ss;
            alu_pkg::op_mulhu:  op_sign = mul_pkg::mul_uu;
            alu_pkg::op_mulhsu: op_sign = mul_pkg::mul_su;
            default:            is_mul_op = 1'b0;
        endcase
    end

    // ====================
    // state machine
    // ====================
    always_comb begin
        next_state = state;
        unique case (state)
            mul_pkg::seq_idle: begin
                if (is_mul_op && !stall) begin
                    next_state = mul_pkg::seq_request;
                end
            end
            mul_pkg::seq_request: begin
                if (mul.valid && mul.ready) begin
                    next_state = mul_pkg::seq_wait;
                end
            end
            mul_pkg::seq_wait: begin
                if (mul.done) begin
                    next_state = mul_pkg::seq_idle;
                end
            end
            default: next_state = mul_pkg::seq_idle;
        endcase
    end

    // a stalled flush waits
    assign clear   = rst || (flush && !stall);
    assign launch  = (state == mul_pkg::seq_idle) && (next_state == mul_pkg::seq_request);
    assign accept  = (state == mul_pkg::seq_request) && (next_state == mul_pkg::seq_wait);
    assign finish  = (state == mul_pkg::seq_wait) && (next_state == mul_pkg::seq_idle);
    assign capture = (state == mul_pkg::seq_idle) && !stall && !is_mul_op;

    always_ff @(posedge clk) begin
        if (clear) begin
            state     <= mul_pkg::seq_idle;
            mul.valid <= 1'b0;
            alu_valid <= 1'b1;
        end else begin
            state <= next_state;
            if (launch) begin
                mul.valid <= 1'b1;
                alu_valid <= 1'b0;
            end else if (accept) begin
                mul.valid <= 1'b0;
            end else if (finish) begin
                alu_valid <= 1'b1;
            end
        end
    end

    // request fields, stable while valid is up
    always_ff @(posedge clk) begin
        if (launch) begin
            mul.word         <= word;
            mul.sign         <= op_sign;
            mul.multiplicand <= a_cut;
            mul.multiplier   <= b_cut;
            sel_hi           <= want_hi;
        end
    end

    // ====================
    // registered outputs
    // ====================
    always_ff @(posedge clk) begin
        if (clear) begin
            result <= '0;
            less   <= 1'b0;
            zero   <= 1'b0;
        end else if (capture) begin
            result <= comb_result;
            less   <= comb_less;
            zero   <= comb_zero;
        end else if (finish) begin
            result <= sel_hi ? mul.hi : mul.lo;
        end
    end

endmodule

// File: verilog/alu_multiplier.sv
// ====================
// iterative shift-add multiplier, one bit per cycle
// ====================

`timescale 1ns/1ps

`include "alu_defs.svh"

module alu_multiplier (
    input  logic clk,
    input  logic rst,
    mul_if.responder mul
);

    localparam int X     = `ALU_XLEN;
    localparam int W     = `ALU_WORD_W;
    localparam int CNT_W = $clog2(`ALU_XLEN + 1);

    logic             busy;
    logic             done_q;
    logic [CNT_W-1:0] count;
    logic             last;
    logic             accept;

    alu_pkg::xlen_t   a_ext;
    alu_pkg::xlen_t   b_ext;
    logic             a_neg;
    logic             b_neg;
    alu_pkg::xlen_t   mag_a;
    alu_pkg::xlen_t   mag_b;

    logic [2*X-1:0]   prod;
    alu_pkg::xlen_t   mcand;
    logic             neg;
    logic             word_q;
    logic [X:0]       step_sum;

    assign accept = mul.valid && mul.ready;
    assign last   = (count == CNT_W'(X));

    // ====================
    // operand magnitudes
    // ====================
    always_comb begin
        a_ext = mul.multiplicand;
        b_ext = mul.multiplier;
        a_neg = (mul.sign != mul_pkg::mul_uu) && mul.multiplicand[X-1];
        b_neg = (mul.sign == mul_pkg::mul_ss) && mul.multiplier[X-1];
        // word mode is always signed by signed on the low half
        if (mul.word) begin
            a_ext = {{(X-W){mul.multiplicand[W-1]}}, mul.multiplicand[W-1:0]};
            b_ext = {{(X-W){mul.multiplier[W-1]}}, mul.multiplier[W-1:0]};
            a_neg = mul.multiplicand[W-1];
            b_neg = mul.multiplier[W-1];
        end
        mag_a = a_neg ? -a_ext : a_ext;
        mag_b = b_neg ? -b_ext : b_ext;
    end

    // add multiplicand into the upper half when the low bit is set
    assign step_sum = {1'b0, prod[2*X-1:X]} + (prod[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            count  <= '0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                if (last) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prod   <= {{X{1'b0}}, mag_b};
            mcand  <= mag_a;
            neg    <= a_neg ^ b_neg;
            word_q <= mul.word;
        end else if (busy) begin
            if (last) begin
                prod <= neg ? -prod : prod;
            end else begin
                prod <= {step_sum, prod[X-1:1]};
            end
        end
    end

    // ====================
    // response
    // ====================
    assign mul.ready = !busy && !done_q;
    assign mul.done  = done_q;
    assign mul.hi    = prod[2*X-1:X];
    assign mul.lo    = word_q ? {{(X-W){prod[W-1]}}, prod[W-1:0]} : prod[X-1:0];

endmodule

// File: verilog/alu_top.sv
// ====================
// execute ALU top with multiplier
// ====================

`timescale 1ns/1ps

module alu_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             stall,
    input  alu_pkg::alu_op_e op,
    input  logic             word,
    input  alu_pkg::xlen_t   da,
    input  alu_pkg::xlen_t   db,
    output logic             alu_valid,
    output alu_pkg::xlen_t   result,
    output logic             less,
    output logic             zero
);

    alu_pkg::xlen_t a_cut;
    alu_pkg::xlen_t b_cut;
    alu_pkg::xlen_t comb_result;
    logic           comb_less;
    logic           comb_zero;

    mul_if i_mul_if ();

    alu_datapath i_datapath (
        .op          (op),
        .word        (word),
        .da          (da),
        .db          (db),
        .a_cut       (a_cut),
        .b_cut       (b_cut),
        .comb_result (comb_result),
        .comb_less   (comb_less),
        .comb_zero   (comb_zero)
    );

    alu_sequencer i_sequencer (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .stall       (stall),
        .op          (op),
        .word        (word),
        .a_cut       (a_cut),
        .b_cut       (b_cut),
        .comb_result (comb_result),
        .comb_less   (comb_less),
        .comb_zero   (comb_zero),
        .mul         (i_mul_if),
        .alu_valid   (alu_valid),
        .result      (result),
        .less        (less),
        .zero        (zero)
    );

    alu_multiplier i_multiplier (
        .clk (clk),
        .rst (rst),
        .mul (i_mul_if)
    );

endmodule

// File: dv/tb_alu.sv
// ====================
// testbench for the execute ALU, reference model and assertions
// ====================

`timescale 1ns/1ps

`include "alu_defs.svh"

module tb_alu;

    logic             clk = 1'b0;
    logic             rst;
    logic             flush;
    logic             stall;
    alu_pkg::alu_op_e op;
    logic             word;
    alu_pkg::xlen_t   da;
    alu_pkg::xlen_t   db;
    logic             alu_valid;
    alu_pkg::xlen_t   result;
    logic             less;
    logic             zero;

    integer           seed = 91004;
    int               checks = 0;
    int               errors = 0;
    alu_pkg::xlen_t   exp_result;
    logic             exp_less;
    logic             exp_zero;
    logic             mul_op_in;

    alu_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .stall     (stall),
        .op        (op),
        .word      (word),
        .da        (da),
        .db        (db),
        .alu_valid (alu_valid),
        .result    (result),
        .less      (less),
        .zero      (zero)
    );

    always #10 clk = ~clk;

    assign mul_op_in = (op == alu_pkg::op_mul) || (op == alu_pkg::op_mulh) ||
                       (op == alu_pkg::op_mulhu) || (op == alu_pkg::op_mulhsu);

    // ====================
    // concurrent checks
    // ====================
    // outputs hold while idle and stalled
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (stall && alu_valid) |=> ($stable(result) && $stable(less) && $stable(zero)))
    else begin
        errors++;
        $display("Error: time %0t result, less or zero changed while stall was high", $time);
    end

    launch_drops_valid: assert property (@(posedge clk) disable iff (rst)
        (alu_valid && !stall && !flush && mul_op_in) |=> !alu_valid)
    else begin
        errors++;
        $display("Error: time %0t signal alu_valid expected 0 actual %b",
                 $time, $sampled(alu_valid));
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic alu_pkg::xlen_t random_operand();
        return {$random(seed), $random(seed)};
    endfunction

    // ====================
    // reference model
    // ====================
    task automatic model_single(input alu_pkg::alu_op_e op_in, input logic word_in,
                                input alu_pkg::xlen_t a_in, input alu_pkg::xlen_t b_in);
        alu_pkg::xlen_t       a;
        alu_pkg::xlen_t       b;
        alu_pkg::xlen_t       sum;
        logic [`ALU_XLEN:0]   wide;
        logic                 is_sub;
        logic                 lt;
        a = word_in ? {{(`ALU_XLEN-`ALU_WORD_W){1'b0}}, a_in[`ALU_WORD_W-1:0]} : a_in;
        b = word_in ? {{(`ALU_XLEN-`ALU_WORD_W){1'b0}}, b_in[`ALU_WORD_W-1:0]} : b_in;
        is_sub = (op_in == alu_pkg::op_sub) || (op_in == alu_pkg::op_slt) ||
                 (op_in == alu_pkg::op_sltu);
        sum = is_sub ? a - b : a + b;
        // sign of the exact sum when the adder adds
        wide = {a[`ALU_XLEN-1], a} + {b[`ALU_XLEN-1], b};
        if (op_in == alu_pkg::op_sltu) begin
            lt = (a < b);
        end else if (is_sub) begin
            lt = ($signed(a) < $signed(b));
        end else begin
            lt = wide[`ALU_XLEN];
        end
        exp_less = lt;
        exp_zero = (sum == '0);
        case (op_in)
            alu_pkg::op_add, alu_pkg::op_sub:  exp_result = sum;
            alu_pkg::op_slt, alu_pkg::op_sltu: exp_result = alu_pkg::xlen_t'(lt);
            alu_pkg::op_and:  exp_result = a & b;
            alu_pkg::op_or:   exp_result = a | b;
            alu_pkg::op_xor:  exp_result = a ^ b;
            alu_pkg::op_sll:  exp_result = a << b[`ALU_SHAMT_W-1:0];
            alu_pkg::op_srl:  exp_result = a >> b[`ALU_SHAMT_W-1:0];
            alu_pkg::op_sra:  exp_result = $signed(a) >>> b[`ALU_SHAMT_W-1:0];
            alu_pkg::op_pass: exp_result = b;
            default:          exp_result = '0;
        endcase
    endtask

    task automatic model_mul(input alu_pkg::alu_op_e op_in, input logic word_in,
                             input alu_pkg::xlen_t a_in, input alu_pkg::xlen_t b_in);
        logic [2*`ALU_XLEN-1:0] ea;
        logic [2*`ALU_XLEN-1:0] eb;
        logic [2*`ALU_XLEN-1:0] p;
        if (word_in) begin
            ea = {{(2*`ALU_XLEN-`ALU_WORD_W){a_in[`ALU_WORD_W-1]}}, a_in[`ALU_WORD_W-1:0]};
            eb = {{(2*`ALU_XLEN-`ALU_WORD_W){b_in[`ALU_WORD_W-1]}}, b_in[`ALU_WORD_W-1:0]};
            p = ea * eb;
            exp_result = {{(`ALU_XLEN-`ALU_WORD_W){p[`ALU_WORD_W-1]}}, p[`ALU_WORD_W-1:0]};
        end else begin
            ea = {{`ALU_XLEN{a_in[`ALU_XLEN-1] && op_in != alu_pkg::op_mulhu}}, a_in};
            eb = {{`ALU_XLEN{b_in[`ALU_XLEN-1] &&
                   (op_in == alu_pkg::op_mul || op_in == alu_pkg::op_mulh)}}, b_in};
            p = ea * eb;
            exp_result = (op_in == alu_pkg::op_mul) ? p[`ALU_XLEN-1:0]
                                                    : p[2*`ALU_XLEN-1:`ALU_XLEN];
        end
    endtask

    // ====================
    // checks and stimulus
    // ====================
    task automatic check_value(input string name, input alu_pkg::xlen_t expected,
                               input alu_pkg::xlen_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        check_value("alu_valid", 1, alu_valid);
        check_value("result", exp_result, result);
        check_value("less", exp_less, less);
        check_value("zero", exp_zero, zero);
    endtask

    task automatic finish_run();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic wait_valid(output logic seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!alu_valid && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        seen = alu_valid;
        if (!seen) begin
            errors++;
            $display("timeout at %0t, alu_valid stayed low for 200 cycles", $time);
        end
    endtask

    // all drive tasks start and end on a falling edge
    task automatic run_single(input alu_pkg::alu_op_e op_in, input logic word_in,
                              input alu_pkg::xlen_t a_in, input alu_pkg::xlen_t b_in);
        model_single(op_in, word_in, a_in, b_in);
        op = op_in;
        word = word_in;
        da = a_in;
        db = b_in;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic run_multiply(input alu_pkg::alu_op_e op_in, input logic word_in,
                                input alu_pkg::xlen_t a_in, input alu_pkg::xlen_t b_in);
        logic seen;
        model_mul(op_in, word_in, a_in, b_in);
        op = op_in;
        word = word_in;
        da = a_in;
        db = b_in;
        wait_valid(seen);
        if (seen) begin
            check_outputs();
        end
    endtask

    function automatic alu_pkg::xlen_t mul_operand();
        case (rand_below(4))
            0:       return '0;
            1:       return -alu_pkg::xlen_t'(rand_below(1000) + 1);
            default: return random_operand();
        endcase
    endfunction

    initial begin
        alu_pkg::alu_op_e k;
        alu_pkg::xlen_t   a;
        alu_pkg::xlen_t   b;
        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        op = alu_pkg::op_add;
        word = 1'b0;
        da = '0;
        db = '0;
        exp_result = '0;
        exp_less = 1'b0;
        exp_zero = 1'b0;
        repeat (8) @(negedge clk);
        check_outputs();
        rst = 1'b0;

        // single-cycle ops with equal operands and sign extremes mixed in
        for (int i = 0; i < 200; i++) begin
            k = alu_pkg::alu_op_e'(rand_below(11));
            a = random_operand();
            b = random_operand();
            if (rand_below(8) == 0) b = a;
            if (rand_below(8) == 0) a = {1'b1, {(`ALU_XLEN-1){1'b0}}};
            run_single(k, rand_below(2) == 1, a, b);
        end

        // stall with changing inputs
        run_single(alu_pkg::op_sub, 1'b0, random_operand(), random_operand());
        stall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            op = alu_pkg::alu_op_e'(rand_below(15));
            word = rand_below(2) == 1;
            da = random_operand();
            db = random_operand();
            @(negedge clk);
            check_outputs();
        end
        stall = 1'b0;
        run_single(alu_pkg::op_xor, 1'b0, random_operand(), random_operand());

        // multiplies
        run_multiply(alu_pkg::op_mulh, 1'b0, '1, '1);
        run_multiply(alu_pkg::op_mulhu, 1'b0, '1, '1);
        run_multiply(alu_pkg::op_mulhsu, 1'b0, -alu_pkg::xlen_t'(5), '1);
        for (int i = 0; i < 40; i++) begin
            k = alu_pkg::alu_op_e'(11 + rand_below(4));
            run_multiply(k, (k == alu_pkg::op_mul) && rand_below(2) == 1,
                         mul_operand(), mul_operand());
        end

        // flush during an outstanding multiply
        op = alu_pkg::op_mulh;
        word = 1'b0;
        da = random_operand();
        db = random_operand();
        repeat (12) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        exp_result = '0;
        exp_less = 1'b0;
        exp_zero = 1'b0;
        check_outputs();
        flush = 1'b0;
        run_single(alu_pkg::op_add, 1'b0, random_operand(), random_operand());
        // multiplier still busy so this request sees back-pressure
        run_multiply(alu_pkg::op_mul, 1'b0, random_operand(), random_operand());
        run_single(alu_pkg::op_sltu, 1'b0, random_operand(), random_operand());

        finish_run();
    end

endmodule

// File: project.f
+incdir+verilog
verilog/alu_pkg.sv
verilog/mul_pkg.sv
verilog/mul_if.sv
verilog/alu_shifter.sv
verilog/alu_datapath.sv
verilog/alu_sequencer.sv
verilog/alu_multiplier.sv
verilog/alu_top.sv
dv/tb_alu.sv
